// ==== source/ccu_pkg.sv ====
////////////////////////////////////////////////////////////
// Widths, table depth and the address word shared by the
// collision controller and its testbench
////////////////////////////////////////////////////////////

`default_nettype none

package ccu_pkg;

    localparam int unsigned addr_width = 32;
    localparam int unsigned id_width = 4;
    localparam int unsigned data_width = 32;

    // Cache line geometry
    localparam int unsigned line_bytes = 16;
    localparam int unsigned line_offset_width = $clog2(line_bytes);
    localparam int unsigned line_width = addr_width - line_offset_width;

    // Outstanding lines tracked per direction
    localparam int unsigned table_depth = 4;

    // Byte address or line number plus byte offset
    typedef union packed {
        logic [addr_width-1:0] word;
        struct packed {
            logic [line_width-1:0]        line;
            logic [line_offset_width-1:0] offset;
        } line_view;
    } ccu_addr_u;

endpackage

`default_nettype wire

// ==== source/ccu_addr_if.sv ====
////////////////////////////////////////////////////////////
// One address channel handshake, valid/ready with addr and id
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface ccu_addr_if;
    import ccu_pkg::*;

    logic                valid;
    logic                ready;
    ccu_addr_u           addr;
    logic [id_width-1:0] id;

    // Request source
    modport mgr (
        output valid,
        output addr,
        output id,
        input  ready
    );

    // Request sink
    modport sub (
        input  valid,
        input  addr,
        input  id,
        output ready
    );

    // Read-only view of a channel
    modport mon (
        input valid,
        input addr,
        input id
    );

endinterface

`default_nettype wire

// ==== source/ccu_line_table.sv ====
////////////////////////////////////////////////////////////
// Outstanding cache lines of one direction. Pushed on the
// memory-side handshake, retired by ID on the response
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ccu_line_table (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                push_i,
    input  logic [ccu_pkg::id_width-1:0]        push_id_i,
    input  logic [ccu_pkg::line_width-1:0]      push_line_i,
    // One lookup per gate, index 0 read and index 1 write
    input  logic [1:0][ccu_pkg::line_width-1:0] lookup_line_i,
    input  logic                                retire_i,
    input  logic [ccu_pkg::id_width-1:0]        retire_id_i,
    output logic [1:0]                          hit_o,
    output logic                                full_o
);
    import ccu_pkg::*;

    logic [table_depth-1:0]                               valid_q;
    logic [table_depth-1:0]                               valid_d;
    logic [table_depth-1:0][id_width-1:0]                 id_q;
    logic [table_depth-1:0][line_width-1:0]               line_q;
    logic [table_depth-1:0][$clog2(table_depth)-1:0]      age_q;
    logic [table_depth-1:0][$clog2(table_depth)-1:0]      age_d;
    logic                                                 full_q;
    logic [table_depth-1:0]                               push_sel;
    logic [table_depth-1:0]                               retire_sel;
    logic [$clog2(table_depth)-1:0]                       oldest_age;
    logic                                                 found;

    // Lowest free entry
    always_comb begin
        push_sel = '0;
        for (int i = table_depth - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                push_sel    = '0;
                push_sel[i] = 1'b1;
            end
        end
    end

    // Oldest valid entry with the retired ID
    always_comb begin
        retire_sel = '0;
        oldest_age = '0;
        found      = 1'b0;
        for (int i = 0; i < table_depth; i++) begin
            if (valid_q[i] && id_q[i] == retire_id_i && (!found || age_q[i] > oldest_age)) begin
                retire_sel    = '0;
                retire_sel[i] = retire_i;
                oldest_age    = age_q[i];
                found         = 1'b1;
            end
        end
    end

    // Age counts the younger valid entries
    always_comb begin
        valid_d = (valid_q & ~retire_sel) | (push_i ? push_sel : '0);
        for (int i = 0; i < table_depth; i++) begin
            age_d[i] = age_q[i];
            if (push_i && push_sel[i]) begin
                age_d[i] = '0;
            end else if (valid_q[i] && !retire_sel[i]) begin
                if (push_i) begin
                    age_d[i] = age_d[i] + 1'b1;
                end
                if (|retire_sel && age_q[i] > oldest_age) begin
                    age_d[i] = age_d[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            age_q   <= '0;
            full_q  <= 1'b0;
        end else begin
            valid_q <= valid_d;
            age_q   <= age_d;
            full_q  <= &valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < table_depth; i++) begin
            if (push_i && push_sel[i]) begin
                id_q[i]   <= push_id_i;
                line_q[i] <= push_line_i;
            end
        end
    end

    // Lookups see the registered state only
    always_comb begin
        hit_o = '0;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < table_depth; i++) begin
                if (valid_q[i] && line_q[i] == lookup_line_i[p]) begin
                    hit_o[p] = 1'b1;
                end
            end
        end
    end

    assign full_o = full_q;

    // The gate must hold requests once the table is full
    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_q)
        else $error("line table pushed while full");

    // Memory must only answer IDs it was sent
    assert property (@(posedge clk_i) disable iff (!rst_ni) retire_i |-> found)
        else $error("line table retire of unknown id %0h", retire_id_i);

endmodule

`default_nettype wire

// ==== source/ccu_addr_gate.sv ====
////////////////////////////////////////////////////////////
// Forwards one direction's address requests to memory and
// holds them on a line collision or a full table
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ccu_addr_gate (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    ccu_addr_if.sub                        core,
    ccu_addr_if.mgr                        mem,
    input  logic                           other_lookup_hit_i,
    input  logic                           own_lookup_hit_i,
    input  logic                           own_full_i,
    output logic [ccu_pkg::line_width-1:0] lookup_line_o,
    input  logic                           same_cycle_hit_i
);

    logic hold;

    // Both tables compare the full line number
    assign lookup_line_o = core.addr.line_view.line;

    assign hold = other_lookup_hit_i | own_lookup_hit_i | own_full_i | same_cycle_hit_i;

    // Pass-through when nothing holds the request
    assign mem.valid  = core.valid & ~hold;
    assign mem.addr   = core.addr;
    assign mem.id     = core.id;
    assign core.ready = mem.ready & ~hold;

    // Once forwarded, a request stays on the memory side until memory takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr) && $stable(mem.id))
        else $error("memory request dropped or changed before its handshake");

endmodule

`default_nettype wire

// ==== source/ccu_collision_ctrl.sv ====
////////////////////////////////////////////////////////////
// Collision check between core and memory. Address requests
// wait for outstanding lines, responses retire them
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ccu_collision_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // Core address requests
    input  logic                           core_ar_valid_i,
    input  logic [ccu_pkg::addr_width-1:0] core_ar_addr_i,
    input  logic [ccu_pkg::id_width-1:0]   core_ar_id_i,
    output logic                           core_ar_ready_o,
    input  logic                           core_aw_valid_i,
    input  logic [ccu_pkg::addr_width-1:0] core_aw_addr_i,
    input  logic [ccu_pkg::id_width-1:0]   core_aw_id_i,
    output logic                           core_aw_ready_o,
    // Memory address requests
    output logic                           mem_ar_valid_o,
    output logic [ccu_pkg::addr_width-1:0] mem_ar_addr_o,
    output logic [ccu_pkg::id_width-1:0]   mem_ar_id_o,
    input  logic                           mem_ar_ready_i,
    output logic                           mem_aw_valid_o,
    output logic [ccu_pkg::addr_width-1:0] mem_aw_addr_o,
    output logic [ccu_pkg::id_width-1:0]   mem_aw_id_o,
    input  logic                           mem_aw_ready_i,
    // Memory responses
    input  logic                           mem_r_valid_i,
    input  logic [ccu_pkg::data_width-1:0] mem_r_data_i,
    input  logic [ccu_pkg::id_width-1:0]   mem_r_id_i,
    input  logic                           mem_r_last_i,
    output logic                           mem_r_ready_o,
    input  logic                           mem_b_valid_i,
    input  logic [ccu_pkg::id_width-1:0]   mem_b_id_i,
    output logic                           mem_b_ready_o,
    // Core responses
    output logic                           core_r_valid_o,
    output logic [ccu_pkg::data_width-1:0] core_r_data_o,
    output logic [ccu_pkg::id_width-1:0]   core_r_id_o,
    output logic                           core_r_last_o,
    input  logic                           core_r_ready_i,
    output logic                           core_b_valid_o,
    output logic [ccu_pkg::id_width-1:0]   core_b_id_o,
    input  logic                           core_b_ready_i
);
    import ccu_pkg::*;

    ccu_addr_if core_ar ();
    ccu_addr_if mem_ar ();
    ccu_addr_if core_aw ();
    ccu_addr_if mem_aw ();

    logic [line_width-1:0] rd_lookup_line;
    logic [line_width-1:0] wr_lookup_line;
    logic [1:0]            rd_table_hit;
    logic [1:0]            wr_table_hit;
    logic                  rd_table_full;
    logic                  wr_table_full;
    logic                  same_line_rw;
    logic                  r_retire;
    logic                  b_retire;

    ////////////////////////////////////////////////////////////
    // Address channels
    ////////////////////////////////////////////////////////////

    assign core_ar.valid     = core_ar_valid_i;
    assign core_ar.addr.word = core_ar_addr_i;
    assign core_ar.id        = core_ar_id_i;
    assign core_ar_ready_o   = core_ar.ready;

    assign core_aw.valid     = core_aw_valid_i;
    assign core_aw.addr.word = core_aw_addr_i;
    assign core_aw.id        = core_aw_id_i;
    assign core_aw_ready_o   = core_aw.ready;

    assign mem_ar_valid_o = mem_ar.valid;
    assign mem_ar_addr_o  = mem_ar.addr.word;
    assign mem_ar_id_o    = mem_ar.id;
    assign mem_ar.ready   = mem_ar_ready_i;

    assign mem_aw_valid_o = mem_aw.valid;
    assign mem_aw_addr_o  = mem_aw.addr.word;
    assign mem_aw_id_o    = mem_aw.id;
    assign mem_aw.ready   = mem_aw_ready_i;

    // Write wins when both sides present the same line
    assign same_line_rw = core_aw.valid &&
        (core_aw.addr.line_view.line == core_ar.addr.line_view.line);

    ccu_addr_gate u_read_gate (
        .clk_i,
        .rst_ni,
        .core               (core_ar),
        .mem                (mem_ar),
        .other_lookup_hit_i (wr_table_hit[0]),
        .own_lookup_hit_i   (rd_table_hit[0]),
        .own_full_i         (rd_table_full),
        .lookup_line_o      (rd_lookup_line),
        .same_cycle_hit_i   (same_line_rw)
    );

    ccu_addr_gate u_write_gate (
        .clk_i,
        .rst_ni,
        .core               (core_aw),
        .mem                (mem_aw),
        .other_lookup_hit_i (rd_table_hit[1]),
        .own_lookup_hit_i   (wr_table_hit[1]),
        .own_full_i         (wr_table_full),
        .lookup_line_o      (wr_lookup_line),
        .same_cycle_hit_i   (1'b0)
    );

    ////////////////////////////////////////////////////////////
    // Outstanding line tables
    ////////////////////////////////////////////////////////////

    // Read line is done with its last beat
    assign r_retire = mem_r_valid_i & core_r_ready_i & mem_r_last_i;
    assign b_retire = mem_b_valid_i & core_b_ready_i;

    ccu_line_table u_read_table (
        .clk_i,
        .rst_ni,
        .push_i        (mem_ar.valid & mem_ar.ready),
        .push_id_i     (mem_ar.id),
        .push_line_i   (mem_ar.addr.line_view.line),
        .lookup_line_i ({wr_lookup_line, rd_lookup_line}),
        .retire_i      (r_retire),
        .retire_id_i   (mem_r_id_i),
        .hit_o         (rd_table_hit),
        .full_o        (rd_table_full)
    );

    ccu_line_table u_write_table (
        .clk_i,
        .rst_ni,
        .push_i        (mem_aw.valid & mem_aw.ready),
        .push_id_i     (mem_aw.id),
        .push_line_i   (mem_aw.addr.line_view.line),
        .lookup_line_i ({wr_lookup_line, rd_lookup_line}),
        .retire_i      (b_retire),
        .retire_id_i   (mem_b_id_i),
        .hit_o         (wr_table_hit),
        .full_o        (wr_table_full)
    );

    ////////////////////////////////////////////////////////////
    // Responses
    ////////////////////////////////////////////////////////////

    assign core_r_valid_o = mem_r_valid_i;
    assign core_r_data_o  = mem_r_data_i;
    assign core_r_id_o    = mem_r_id_i;
    assign core_r_last_o  = mem_r_last_i;
    assign mem_r_ready_o  = core_r_ready_i;

    assign core_b_valid_o = mem_b_valid_i;
    assign core_b_id_o    = mem_b_id_i;
    assign mem_b_ready_o  = core_b_ready_i;

endmodule

`default_nettype wire

// ==== verification/tb_ccu_collision_ctrl.sv ====
////////////////////////////////////////////////////////////
// Trace-driven testbench for the collision controller, with
// a memory model and a model of the outstanding lines
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ccu_collision_ctrl;
    import ccu_pkg::*;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  core_ar_valid_i, core_aw_valid_i, core_ar_ready_o, core_aw_ready_o;
    logic [addr_width-1:0] core_ar_addr_i, core_aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
    logic [id_width-1:0]   core_ar_id_i, core_aw_id_i, mem_ar_id_o, mem_aw_id_o;
    logic                  mem_ar_valid_o, mem_aw_valid_o, mem_ar_ready_i, mem_aw_ready_i;
    logic                  mem_r_valid_i, mem_r_last_i, mem_r_ready_o, core_r_ready_i;
    logic [data_width-1:0] mem_r_data_i, core_r_data_o;
    logic [id_width-1:0]   mem_r_id_i, core_r_id_o, mem_b_id_i, core_b_id_o;
    logic                  core_r_valid_o, core_r_last_o, mem_b_valid_i, mem_b_ready_o;
    logic                  core_b_valid_o, core_b_ready_i;

    // Outstanding lines in issue order, tagged with their direction
    logic [line_width-1:0] out_line[$];
    logic [id_width-1:0]   out_id[$];
    bit                    out_wr[$];

    logic [31:0] lcg_state = 32'h990c;
    int          trace_len = 0;
    int          ar_expect = -1;
    int          aw_expect = -1;
    logic        r_fire;
    logic        b_fire;

    ccu_collision_ctrl u_ccu_collision_ctrl (.*);

    always #10 clk_i = ~clk_i;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input ccu_addr_u got, input ccu_addr_u exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h exp %h", name, got.word, exp.word));
        end
    endtask

    task automatic check_id(input string name, input logic [id_width-1:0] got,
                            input logic [id_width-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [line_width-1:0] line_of(input logic [addr_width-1:0] word);
        ccu_addr_u a;
        a.word = word;
        return a.line_view.line;
    endfunction

    function automatic bit line_outstanding(input logic [line_width-1:0] line);
        bit hit;
        hit = 1'b0;
        foreach (out_line[i]) begin
            hit |= (out_line[i] == line);
        end
        return hit;
    endfunction

    function automatic int lines_of_dir(input bit is_write);
        int n;
        n = 0;
        foreach (out_wr[i]) begin
            n += (out_wr[i] == is_write) ? 1 : 0;
        end
        return n;
    endfunction

    // Oldest outstanding line of that direction and ID completes
    task automatic retire_line(input bit is_write, input logic [id_width-1:0] id);
        int idx;
        idx = -1;
        foreach (out_id[i]) begin
            if (idx < 0 && out_wr[i] == is_write && out_id[i] == id) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            fail_run($sformatf("response with ID %h has no outstanding request", id));
        end
        out_line.delete(idx);
        out_id.delete(idx);
        out_wr.delete(idx);
    endtask

    // Check one cycle of DUT outputs, then follow the handshakes at the rising edge
    task automatic run_cycle();
        logic rd_hold;
        logic wr_hold;
        logic ar_fire;
        logic aw_fire;
        #1;
        rd_hold = line_outstanding(line_of(core_ar_addr_i)) || lines_of_dir(0) >= table_depth
            || (core_aw_valid_i && line_of(core_aw_addr_i) == line_of(core_ar_addr_i));
        wr_hold = line_outstanding(line_of(core_aw_addr_i)) || lines_of_dir(1) >= table_depth;
        if (ar_expect >= 0) begin
            check_flag("mem_ar_valid_o", mem_ar_valid_o, ar_expect == 1);
            ar_expect = -1;
        end
        if (aw_expect >= 0) begin
            check_flag("mem_aw_valid_o", mem_aw_valid_o, aw_expect == 1);
            aw_expect = -1;
        end
        check_flag("mem_ar_valid_o", mem_ar_valid_o, core_ar_valid_i && !rd_hold);
        check_flag("mem_aw_valid_o", mem_aw_valid_o, core_aw_valid_i && !wr_hold);
        if (core_ar_valid_i) begin
            check_flag("core_ar_ready_o", core_ar_ready_o, mem_ar_ready_i && !rd_hold);
            check_addr("mem_ar_addr_o", mem_ar_addr_o, core_ar_addr_i);
            check_id("mem_ar_id_o", mem_ar_id_o, core_ar_id_i);
        end
        if (core_aw_valid_i) begin
            check_flag("core_aw_ready_o", core_aw_ready_o, mem_aw_ready_i && !wr_hold);
            check_addr("mem_aw_addr_o", mem_aw_addr_o, core_aw_addr_i);
            check_id("mem_aw_id_o", mem_aw_id_o, core_aw_id_i);
        end
        check_flag("core_r_valid_o", core_r_valid_o, mem_r_valid_i);
        check_flag("mem_r_ready_o", mem_r_ready_o, core_r_ready_i);
        if (mem_r_valid_i) begin
            check_data("core_r_data_o", core_r_data_o, mem_r_data_i);
            check_id("core_r_id_o", core_r_id_o, mem_r_id_i);
            check_flag("core_r_last_o", core_r_last_o, mem_r_last_i);
        end
        check_flag("core_b_valid_o", core_b_valid_o, mem_b_valid_i);
        check_flag("mem_b_ready_o", mem_b_ready_o, core_b_ready_i);
        if (mem_b_valid_i) begin
            check_id("core_b_id_o", core_b_id_o, mem_b_id_i);
        end
        ar_fire = core_ar_valid_i && mem_ar_ready_i && !rd_hold;
        aw_fire = core_aw_valid_i && mem_aw_ready_i && !wr_hold;
        r_fire  = mem_r_valid_i && core_r_ready_i;
        b_fire  = mem_b_valid_i && core_b_ready_i;
        @(posedge clk_i);
        if (ar_fire) begin
            out_line.push_back(line_of(core_ar_addr_i));
            out_id.push_back(core_ar_id_i);
            out_wr.push_back(1'b0);
        end
        if (aw_fire) begin
            out_line.push_back(line_of(core_aw_addr_i));
            out_id.push_back(core_aw_id_i);
            out_wr.push_back(1'b1);
        end
        if (r_fire && mem_r_last_i) begin
            retire_line(1'b0, mem_r_id_i);
        end
        if (b_fire) begin
            retire_line(1'b1, mem_b_id_i);
        end
        @(negedge clk_i);
        if (ar_fire) begin
            core_ar_valid_i = 1'b0;
        end
        if (aw_fire) begin
            core_aw_valid_i = 1'b0;
        end
    endtask

    // Read burst from memory, optionally stalled by the core on its last beat
    task automatic send_read_data(input logic [id_width-1:0] id, input int beats,
                                  input bit stall);
        for (int b = 0; b < beats; b++) begin
            lcg_state     = lcg_next(lcg_state);
            mem_r_valid_i = 1'b1;
            mem_r_id_i    = id;
            mem_r_data_i  = lcg_state;
            mem_r_last_i  = (b == beats - 1);
            if (stall && b == beats - 1) begin
                core_r_ready_i = 1'b0;
                repeat (2) run_cycle();
                core_r_ready_i = 1'b1;
            end
            r_fire = 1'b0;
            while (!r_fire) run_cycle();
        end
        mem_r_valid_i = 1'b0;
        mem_r_last_i  = 1'b0;
    endtask

    task automatic send_write_resp(input logic [id_width-1:0] id, input bit stall);
        mem_b_valid_i = 1'b1;
        mem_b_id_i    = id;
        if (stall) begin
            core_b_ready_i = 1'b0;
            repeat (2) run_cycle();
            core_b_ready_i = 1'b1;
        end
        b_fire = 1'b0;
        while (!b_fire) run_cycle();
        mem_b_valid_i = 1'b0;
    endtask

    // 50 cycles of 20 ns per trace command
    initial begin
        wait (trace_len > 0);
        #(trace_len * 50 * 20);
        fail_run("simulation timed out before the trace completed");
    end

    initial begin
        int                  fd;
        int                  code;
        logic [63:0]         cmd;
        logic [id_width-1:0] id;
        logic [31:0]         val;
        logic [15:0]         res;
        logic [8*128-1:0]    rest;
        logic [63:0]         cmd_q[$];
        logic [id_width-1:0] id_q[$];
        logic [31:0]         val_q[$];
        logic [15:0]         res_q[$];
        {core_ar_valid_i, core_aw_valid_i, mem_r_valid_i, mem_r_last_i, mem_b_valid_i} = '0;
        {core_ar_addr_i, core_aw_addr_i, core_ar_id_i, core_aw_id_i} = '0;
        {mem_r_data_i, mem_r_id_i, mem_b_id_i} = '0;
        {mem_ar_ready_i, mem_aw_ready_i, core_r_ready_i, core_b_ready_i} = '1;
        rst_ni = 1'b0;

        fd = $fopen("verification/ccu_trace.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the trace file verification/ccu_trace.txt");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                void'($fgets(rest, fd));
            end else begin
                code = $fscanf(fd, "%h %h %s", id, val, res);
                if (code != 3) begin
                    fail_run("trace line does not hold four columns");
                end
                cmd_q.push_back(cmd);
                id_q.push_back(id);
                val_q.push_back(val);
                res_q.push_back(res);
            end
        end
        $fclose(fd);
        if (cmd_q.size() == 0) begin
            fail_run("trace file holds no commands");
        end
        trace_len = cmd_q.size();

        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (cmd_q[n]) begin
            case (cmd_q[n])
                "AR": begin
                    while (core_ar_valid_i) run_cycle();
                    core_ar_valid_i = 1'b1;
                    core_ar_addr_i  = val_q[n];
                    core_ar_id_i    = id_q[n];
                    ar_expect       = (res_q[n] == "P") ? 1 : 0;
                end
                "AW": begin
                    while (core_aw_valid_i) run_cycle();
                    core_aw_valid_i = 1'b1;
                    core_aw_addr_i  = val_q[n];
                    core_aw_id_i    = id_q[n];
                    aw_expect       = (res_q[n] == "P") ? 1 : 0;
                end
                "R":    send_read_data(id_q[n], val_q[n], res_q[n] == "S");
                "B":    send_write_resp(id_q[n], res_q[n] == "S");
                "WAIT": begin
                    // L keeps memory ready low during and after the wait
                    mem_ar_ready_i = (res_q[n] != "L");
                    mem_aw_ready_i = (res_q[n] != "L");
                    repeat (val_q[n]) run_cycle();
                end
                default: fail_run($sformatf("unknown trace command %s", cmd_q[n]));
            endcase
        end
        mem_ar_ready_i = 1'b1;
        mem_aw_ready_i = 1'b1;
        while (core_ar_valid_i || core_aw_valid_i) run_cycle();
        run_cycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ccu_trace.txt ====
# cmd  id  value     result
# AR/AW: byte address, P passes at once or H held. R: beat count, B: 0. S stalls the core
# WAIT: cycle count, L keeps memory ready low. AR and AW take no cycle of their own
AR   1  00001000  P
AW   2  00002000  P
WAIT 0  1         P
R    1  2         P
B    2  0         P
AR   3  00003000  P
WAIT 0  1         P
AW   4  00003008  H
WAIT 0  2         P
R    3  2         S
WAIT 0  1         P
B    4  0         P
AW   5  00004000  P
WAIT 0  1         P
AR   6  00004004  H
WAIT 0  2         P
B    5  0         S
WAIT 0  1         P
R    6  1         P
AW   7  00005000  P
AR   8  0000500c  H
WAIT 0  1         P
B    7  0         P
WAIT 0  1         P
R    8  1         P
AR   1  00006000  P
WAIT 0  1         P
AR   2  00006100  P
WAIT 0  1         P
AR   3  00006200  P
WAIT 0  1         P
AR   4  00006300  P
WAIT 0  1         P
AR   5  00006400  H
AW   6  00007000  P
WAIT 0  2         P
R    2  1         P
WAIT 0  1         P
B    6  0         P
R    1  1         P
R    3  1         P
R    4  1         P
R    5  1         P
WAIT 0  0         L
AR   9  00008000  P
AW   a  00009000  P
WAIT 0  2         L
WAIT 0  1         P
R    9  1         P
B    a  0         P
WAIT 0  1         P

// ==== build.f ====
source/ccu_pkg.sv
source/ccu_addr_if.sv
source/ccu_line_table.sv
source/ccu_addr_gate.sv
source/ccu_collision_ctrl.sv
verification/tb_ccu_collision_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_ccu_collision_ctrl -o Vtb_ccu_collision_ctrl || exit 1

./obj_dir/Vtb_ccu_collision_ctrl > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && echo "simulation failed" && exit 1
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
